//--- rtl/rvWbPkg.sv
`default_nettype none

package rvWbPkg;

	typedef logic [31:0] dataWord;
	typedef logic [4:0] regIndex;
	typedef logic [11:0] csrAddress;
	typedef logic [3:0] byteMask;

	// Major opcodes
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opAluImm = 7'b0010011;
	localparam logic [6:0] opAlu = 7'b0110011;
	localparam logic [6:0] opFence = 7'b0001111;
	localparam logic [6:0] opSystem = 7'b1110011;

	// Load widths, stores share the low three
	localparam logic [2:0] loadByte = 3'b000;
	localparam logic [2:0] loadHalf = 3'b001;
	localparam logic [2:0] loadWord = 3'b010;
	localparam logic [2:0] loadByteU = 3'b100;
	localparam logic [2:0] loadHalfU = 3'b101;

	// CSR op in funct3[1:0], bit 2 picks the immediate form
	localparam logic [1:0] csrOpRw = 2'b01;
	localparam logic [1:0] csrOpRs = 2'b10;
	localparam logic [1:0] csrOpRc = 2'b11;

	localparam csrAddress csrMtvec = 12'h305;
	localparam csrAddress csrMscratch = 12'h340;
	localparam csrAddress csrMepc = 12'h341;
	localparam csrAddress csrMcause = 12'h342;

endpackage

`default_nettype wire

//--- rtl/PipeStage.sv
`timescale 1ns/100ps
`default_nettype none

module PipeStage (
	input wire clk,
	input wire arstN,
	input wire stepPipe,
	input wire pipeStall,
	input wire rvWbPkg::dataWord currentInstruction,
	output logic currentPipeStall,
	output logic active,
	output rvWbPkg::dataWord lastInstruction
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			currentPipeStall <= 1'b0;
			active <= 1'b0;
			lastInstruction <= '0;
		end else if (stepPipe) begin
			currentPipeStall <= pipeStall;
			active <= 1'b1;
			// Bubbles leave the last real instruction visible
			if (!pipeStall) begin
				lastInstruction <= currentInstruction;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/InstructionDecode.sv
`timescale 1ns/100ps
`default_nettype none

module InstructionDecode (
	input wire rvWbPkg::dataWord currentInstruction,
	input wire isNOP,
	output logic [6:0] opcode,
	output rvWbPkg::regIndex rdIndex,
	output rvWbPkg::regIndex rs1Index,
	output rvWbPkg::regIndex rs2Index,
	output logic [2:0] funct3,
	output logic [6:0] funct7,
	output logic isCompressed,
	output logic isLUI,
	output logic isAUIPC,
	output logic isJAL,
	output logic isJALR,
	output logic isBranch,
	output logic isLoad,
	output logic isStore,
	output logic isALUImm,
	output logic isALU,
	output logic isFence,
	output logic isSystem,
	output logic isCSR,
	output logic isCSRRW,
	output logic isCSRRS,
	output logic isCSRRC,
	output logic isECALL,
	output logic isEBREAK,
	output logic isRET,
	output logic invalidInstruction
);
	import rvWbPkg::*;

	logic valid;
	logic shiftLegal;
	logic aluLegal;
	logic isPriv;
	logic [11:0] funct12;

	assign opcode = currentInstruction[6:0];
	assign rdIndex = currentInstruction[11:7];
	assign funct3 = currentInstruction[14:12];
	assign rs1Index = currentInstruction[19:15];
	assign rs2Index = currentInstruction[24:20];
	assign funct7 = currentInstruction[31:25];
	assign funct12 = currentInstruction[31:20];

	// A stalled slot decodes as nothing at all
	assign valid = !isNOP;

	assign isCompressed = valid && currentInstruction[1:0] != 2'b11;
	assign isLUI = valid && opcode == opLui;
	assign isAUIPC = valid && opcode == opAuipc;
	assign isJAL = valid && opcode == opJal;
	assign isJALR = valid && opcode == opJalr && funct3 == 3'b000;
	assign isBranch = valid && opcode == opBranch && funct3[2:1] != 2'b01;
	assign isLoad = valid && opcode == opLoad
		&& (funct3 == loadByte || funct3 == loadHalf || funct3 == loadWord
		|| funct3 == loadByteU || funct3 == loadHalfU);
	assign isStore = valid && opcode == opStore && !funct3[2] && funct3[1:0] != 2'b11;

	// Immediate shifts keep funct7 in the upper immediate bits
	assign shiftLegal = (funct3 == 3'b001) ? funct7 == 7'b0000000
		: (funct7 == 7'b0000000 || funct7 == 7'b0100000);
	assign isALUImm = valid && opcode == opAluImm && (funct3[1:0] != 2'b01 || shiftLegal);

	// Only SUB and SRA use the alternate funct7
	assign aluLegal = funct7 == 7'b0000000
		|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
	assign isALU = valid && opcode == opAlu && aluLegal;

	assign isFence = valid && opcode == opFence && funct3 == 3'b000;
	assign isSystem = valid && opcode == opSystem;

	assign isCSR = isSystem && funct3[1:0] != 2'b00;
	assign isCSRRW = isCSR && funct3[1:0] == csrOpRw;
	assign isCSRRS = isCSR && funct3[1:0] == csrOpRs;
	assign isCSRRC = isCSR && funct3[1:0] == csrOpRc;

	// ECALL, EBREAK and MRET differ only in funct12
	assign isPriv = isSystem && funct3 == 3'b000 && rdIndex == '0 && rs1Index == '0;
	assign isECALL = isPriv && funct12 == 12'h000;
	assign isEBREAK = isPriv && funct12 == 12'h001;
	assign isRET = isPriv && funct12 == 12'h302;

	assign invalidInstruction = valid && !(isLUI || isAUIPC || isJAL || isJALR || isBranch
		|| isLoad || isStore || isALUImm || isALU || isFence || isCSR
		|| isECALL || isEBREAK || isRET);

endmodule

`default_nettype wire

//--- rtl/LoadAlign.sv
`timescale 1ns/100ps
`default_nettype none

module LoadAlign (
	input wire [2:0] funct3,
	input wire isLoad,
	input wire isStore,
	input wire [1:0] addressLow,
	input wire rvWbPkg::dataWord memoryDataRead,
	output rvWbPkg::dataWord loadData,
	output logic shouldLoad
);
	import rvWbPkg::*;

	byteMask baseMask;
	logic [6:0] laneMask;
	logic misaligned;
	logic isSigned;
	logic signBit;
	dataWord shifted;

	always_comb begin
		baseMask = 4'b0000;
		if (isLoad || isStore) begin
			case (funct3)
				loadByte, loadByteU: baseMask = 4'b0001;
				loadHalf, loadHalfU: baseMask = 4'b0011;
				loadWord: baseMask = 4'b1111;
				default: baseMask = 4'b0000;
			endcase
		end
	end

	// Lanes pushed past bit 3 fall outside the word
	assign laneMask = {3'b000, baseMask} << addressLow;
	assign misaligned = |laneMask[6:4];
	assign shouldLoad = isLoad && !misaligned;

	assign shifted = memoryDataRead >> {addressLow, 3'b000};
	assign isSigned = funct3 == loadByte || funct3 == loadHalf;

	always_comb begin
		case (baseMask)
			4'b0001: signBit = isSigned && shifted[7];
			4'b0011: signBit = isSigned && shifted[15];
			default: signBit = 1'b0;
		endcase
	end

	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			loadData[lane*8 +: 8] = baseMask[lane] ? shifted[lane*8 +: 8] : {8{signBit}};
		end
	end

endmodule

`default_nettype wire

//--- rtl/PipeStore.sv
`timescale 1ns/100ps
`default_nettype none

module PipeStore (
	input wire clk,
	input wire arstN,
	input wire stepPipe,
	input wire pipeStall,
	input wire rvWbPkg::dataWord currentInstruction,
	input wire rvWbPkg::dataWord memoryDataRead,
	input wire rvWbPkg::dataWord aluResultData,
	input wire rvWbPkg::dataWord csrData,
	output wire currentPipeStall,
	output wire active,
	output wire rvWbPkg::dataWord lastInstruction,
	output wire invalidInstruction,
	output wire expectingLoad,
	output wire isFence,
	output wire isRET,
	output wire rvWbPkg::regIndex registerWriteAddress,
	output rvWbPkg::dataWord registerWriteData,
	output wire registerWriteEnable,
	output wire rvWbPkg::csrAddress csrWriteAddress,
	output wire rvWbPkg::dataWord csrWriteData,
	output wire csrWriteEnable
);
	import rvWbPkg::*;

	regIndex rdIndex;
	logic [2:0] funct3;
	logic isLUI, isAUIPC, isJAL, isJALR, isLoad, isStore;
	logic isALUImm, isALU, isCSR, isCSRRW;
	logic shouldLoad;
	logic csrWrite;
	logic resultWrite;
	logic retiring;
	dataWord loadData;

	PipeStage pipeStage (
		.clk(clk),
		.arstN(arstN),
		.stepPipe(stepPipe),
		.pipeStall(pipeStall),
		.currentInstruction(currentInstruction),
		.currentPipeStall(currentPipeStall),
		.active(active),
		.lastInstruction(lastInstruction)
	);

	InstructionDecode decode (
		.currentInstruction(currentInstruction),
		.isNOP(pipeStall),
		.opcode(),
		.rdIndex(rdIndex),
		.rs1Index(),
		.rs2Index(),
		.funct3(funct3),
		.funct7(),
		.isCompressed(),
		.isLUI(isLUI),
		.isAUIPC(isAUIPC),
		.isJAL(isJAL),
		.isJALR(isJALR),
		.isBranch(),
		.isLoad(isLoad),
		.isStore(isStore),
		.isALUImm(isALUImm),
		.isALU(isALU),
		.isFence(isFence),
		.isSystem(),
		.isCSR(isCSR),
		.isCSRRW(isCSRRW),
		.isCSRRS(),
		.isCSRRC(),
		.isECALL(),
		.isEBREAK(),
		.isRET(isRET),
		.invalidInstruction(invalidInstruction)
	);

	// The ALU result doubles as the load address
	LoadAlign loadAlign (
		.funct3(funct3),
		.isLoad(isLoad),
		.isStore(isStore),
		.addressLow(aluResultData[1:0]),
		.memoryDataRead(memoryDataRead),
		.loadData(loadData),
		.shouldLoad(shouldLoad)
	);

	// CSRRS and CSRRC with rd = x0 are pure reads
	assign csrWrite = isCSRRW || (isCSR && rdIndex != '0);
	assign resultWrite = isLUI || isAUIPC || isJAL || isJALR || isALU || isALUImm
		|| isLoad || csrWrite;

	// Misaligned loads drop through to zero
	always_comb begin
		priority case (1'b1)
			isLUI, isAUIPC, isJAL, isJALR: registerWriteData = aluResultData;
			shouldLoad: registerWriteData = loadData;
			isALU, isALUImm: registerWriteData = aluResultData;
			csrWrite: registerWriteData = csrData;
			default: registerWriteData = '0;
		endcase
	end

	assign retiring = stepPipe && !pipeStall;
	assign expectingLoad = shouldLoad;

	assign registerWriteAddress = rdIndex;
	assign registerWriteEnable = resultWrite && retiring;

	assign csrWriteAddress = currentInstruction[31:20];
	assign csrWriteData = aluResultData;
	assign csrWriteEnable = csrWrite && retiring;

endmodule

`default_nettype wire

//--- rtl/RegisterFile.sv
`timescale 1ns/100ps
`default_nettype none

module RegisterFile #(
	parameter int registerCount = 32
) (
	input wire clk,
	input wire arstN,
	input wire rvWbPkg::regIndex writeAddress,
	input wire rvWbPkg::dataWord writeData,
	input wire writeEnable,
	input wire rvWbPkg::regIndex debugAddress,
	output rvWbPkg::dataWord debugData
);
	import rvWbPkg::*;

	// x0 has no storage
	dataWord registers [1:registerCount-1];
	logic writeHit;
	logic debugHit;

	assign writeHit = writeAddress != '0 && 32'(writeAddress) < registerCount;
	assign debugHit = debugAddress != '0 && 32'(debugAddress) < registerCount;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < registerCount; i++) begin
				registers[i] <= '0;
			end
		end else if (writeEnable && writeHit) begin
			registers[writeAddress] <= writeData;
		end
	end

	assign debugData = debugHit ? registers[debugAddress] : '0;

endmodule

`default_nettype wire

//--- rtl/CsrFile.sv
`timescale 1ns/100ps
`default_nettype none

module CsrFile (
	input wire clk,
	input wire arstN,
	input wire rvWbPkg::csrAddress readAddress,
	output rvWbPkg::dataWord readData,
	input wire rvWbPkg::csrAddress writeAddress,
	input wire rvWbPkg::dataWord writeData,
	input wire writeEnable,
	input wire rvWbPkg::csrAddress debugAddress,
	output rvWbPkg::dataWord debugData
);
	import rvWbPkg::*;

	dataWord mtvec, mscratch, mepc, mcause;

	function automatic dataWord lookup(csrAddress address);
		case (address)
			csrMtvec: return mtvec;
			csrMscratch: return mscratch;
			csrMepc: return mepc;
			csrMcause: return mcause;
			default: return '0;
		endcase
	endfunction

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mtvec <= '0;
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (writeEnable) begin
			// Vector base and return address are word aligned
			case (writeAddress)
				csrMtvec: mtvec <= {writeData[31:2], 2'b00};
				csrMscratch: mscratch <= writeData;
				csrMepc: mepc <= {writeData[31:2], 2'b00};
				csrMcause: mcause <= writeData;
				default: ;
			endcase
		end
	end

	always_comb begin
		readData = lookup(readAddress);
	end

	always_comb begin
		debugData = lookup(debugAddress);
	end

endmodule

`default_nettype wire

//--- rtl/WritebackTop.sv
`timescale 1ns/100ps
`default_nettype none

module WritebackTop #(
	parameter int registerCount = 32
) (
	input wire clk,
	input wire arstN,
	input wire stepPipe,
	input wire pipeStall,
	input wire rvWbPkg::dataWord currentInstruction,
	input wire rvWbPkg::dataWord aluResultData,
	input wire rvWbPkg::dataWord memoryDataRead,
	input wire rvWbPkg::regIndex debugRegisterAddress,
	input wire rvWbPkg::csrAddress debugCsrAddress,
	output wire active,
	output wire currentPipeStall,
	output wire rvWbPkg::dataWord lastInstruction,
	output wire invalidInstruction,
	output wire expectingLoad,
	output wire isFence,
	output wire isRET,
	output wire rvWbPkg::dataWord debugRegisterData,
	output wire rvWbPkg::dataWord debugCsrData
);
	import rvWbPkg::*;

	wire regIndex registerWriteAddress;
	wire dataWord registerWriteData;
	wire registerWriteEnable;
	wire csrAddress csrWriteAddress;
	wire dataWord csrWriteData;
	wire csrWriteEnable;
	wire dataWord csrData;

	PipeStore pipeStore (
		.clk(clk),
		.arstN(arstN),
		.stepPipe(stepPipe),
		.pipeStall(pipeStall),
		.currentInstruction(currentInstruction),
		.memoryDataRead(memoryDataRead),
		.aluResultData(aluResultData),
		.csrData(csrData),
		.currentPipeStall(currentPipeStall),
		.active(active),
		.lastInstruction(lastInstruction),
		.invalidInstruction(invalidInstruction),
		.expectingLoad(expectingLoad),
		.isFence(isFence),
		.isRET(isRET),
		.registerWriteAddress(registerWriteAddress),
		.registerWriteData(registerWriteData),
		.registerWriteEnable(registerWriteEnable),
		.csrWriteAddress(csrWriteAddress),
		.csrWriteData(csrWriteData),
		.csrWriteEnable(csrWriteEnable)
	);

	RegisterFile #(
		.registerCount(registerCount)
	) registerFile (
		.clk(clk),
		.arstN(arstN),
		.writeAddress(registerWriteAddress),
		.writeData(registerWriteData),
		.writeEnable(registerWriteEnable),
		.debugAddress(debugRegisterAddress),
		.debugData(debugRegisterData)
	);

	// Old CSR value comes from the address field of the instruction
	CsrFile csrFile (
		.clk(clk),
		.arstN(arstN),
		.readAddress(currentInstruction[31:20]),
		.readData(csrData),
		.writeAddress(csrWriteAddress),
		.writeData(csrWriteData),
		.writeEnable(csrWriteEnable),
		.debugAddress(debugCsrAddress),
		.debugData(debugCsrData)
	);

endmodule

`default_nettype wire

//--- sim/WritebackTop_assert.sv
`timescale 1ns/100ps
`default_nettype none

module WritebackAssert (
	input wire clk,
	input wire arstN,
	input wire pipeStall,
	input wire registerWriteEnable,
	input wire csrWriteEnable,
	input wire expectingLoad,
	input wire rvWbPkg::dataWord currentInstruction,
	input wire active
);
	import rvWbPkg::*;

	// A bubble never touches architectural state
	stallNoWrite: assert property (@(posedge clk) disable iff (!arstN)
		pipeStall |-> !(registerWriteEnable || csrWriteEnable))
		else $error("register or CSR write enable high during a stall");

	// Load opcode in an unstalled slot
	loadOnlyOnLoad: assert property (@(posedge clk) disable iff (!arstN)
		expectingLoad |-> (currentInstruction[6:0] == opLoad && !pipeStall))
		else $error("expectingLoad high without a load in the slot");

	// Sticky until the next reset
	activeSticky: assert property (@(posedge clk) disable iff (!arstN)
		active |=> active)
		else $error("active fell while out of reset");

endmodule

bind WritebackTop WritebackAssert writebackChecks (
	.clk(clk),
	.arstN(arstN),
	.pipeStall(pipeStall),
	.registerWriteEnable(registerWriteEnable),
	.csrWriteEnable(csrWriteEnable),
	.expectingLoad(expectingLoad),
	.currentInstruction(currentInstruction),
	.active(active)
);

`default_nettype wire

//--- sim/WritebackTb.sv
`timescale 1ns/100ps
`default_nettype none

module WritebackTb;
	import rvWbPkg::*;

	localparam int clockPeriod = 8;
	localparam int testCount = 5;

	logic clk;
	logic arstN;
	logic stepPipe;
	logic pipeStall;
	dataWord currentInstruction;
	dataWord aluResultData;
	dataWord memoryDataRead;
	regIndex debugRegisterAddress;
	csrAddress debugCsrAddress;
	wire active;
	wire currentPipeStall;
	wire dataWord lastInstruction;
	wire invalidInstruction;
	wire expectingLoad;
	wire isFence;
	wire isRET;
	wire dataWord debugRegisterData;
	wire dataWord debugCsrData;

	WritebackTop #(
		.registerCount(32)
	) UUT (
		.clk(clk),
		.arstN(arstN),
		.stepPipe(stepPipe),
		.pipeStall(pipeStall),
		.currentInstruction(currentInstruction),
		.aluResultData(aluResultData),
		.memoryDataRead(memoryDataRead),
		.debugRegisterAddress(debugRegisterAddress),
		.debugCsrAddress(debugCsrAddress),
		.active(active),
		.currentPipeStall(currentPipeStall),
		.lastInstruction(lastInstruction),
		.invalidInstruction(invalidInstruction),
		.expectingLoad(expectingLoad),
		.isFence(isFence),
		.isRET(isRET),
		.debugRegisterData(debugRegisterData),
		.debugCsrData(debugCsrData)
	);

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	task automatic abortRun();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic checkValue(input string name, input dataWord actual, input dataWord expected);
		assert (actual === expected) else begin
			$display("ERROR: %s is %h, expected %h", name, actual, expected);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		checkValue(name, 32'(actual), 32'(expected));
	endtask

	task automatic checkRegister(input regIndex index, input dataWord expected);
		debugRegisterAddress = index;
		#1;
		checkValue($sformatf("x%0d", index), debugRegisterData, expected);
	endtask

	task automatic checkCsr(input csrAddress address, input dataWord expected);
		debugCsrAddress = address;
		#1;
		checkValue($sformatf("csr %h", address), debugCsrData, expected);
	endtask

	function automatic dataWord rType(input logic [6:0] funct7, input regIndex rs2,
		input regIndex rs1, input logic [2:0] funct3, input regIndex rd);
		return {funct7, rs2, rs1, funct3, rd, opAlu};
	endfunction

	function automatic dataWord iType(input logic [11:0] imm, input regIndex rs1,
		input logic [2:0] funct3, input regIndex rd, input logic [6:0] opcode);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	// Expected load result straight from the lane and extension rule
	function automatic dataWord alignedLoad(input logic [2:0] width, input logic [1:0] offset,
		input dataWord word);
		dataWord lanes;
		lanes = word >> {offset, 3'b000};
		case (width)
			loadByte: return {{24{lanes[7]}}, lanes[7:0]};
			loadHalf: return {{16{lanes[15]}}, lanes[15:0]};
			loadByteU: return {24'h000000, lanes[7:0]};
			loadHalfU: return {16'h0000, lanes[15:0]};
			default: return lanes;
		endcase
	endfunction

	// Drives one slot just after the edge, then lets decode settle
	task automatic present(input dataWord word, input dataWord alu, input dataWord memory,
		input logic stall, input logic stepping);
		@(posedge clk);
		#1;
		currentInstruction = word;
		aluResultData = alu;
		memoryDataRead = memory;
		pipeStall = stall;
		stepPipe = stepping;
		#1;
	endtask

	task automatic retire();
		@(posedge clk);
		#1;
		stepPipe = 1'b0;
		pipeStall = 1'b0;
	endtask

	task automatic runStep(input dataWord word, input dataWord alu, input dataWord memory);
		present(word, alu, memory, 1'b0, 1'b1);
		retire();
	endtask

	task automatic writeAndCheck(input dataWord word, input regIndex rd);
		dataWord value;
		value = $urandom;
		runStep(word, value, '0);
		checkRegister(rd, (rd == '0) ? '0 : value);
	endtask

	task automatic resultWrites();
		dataWord word;
		word = {20'habcde, 5'd5, opLui};
		writeAndCheck(word, 5'd5);
		checkFlag("active", active, 1'b1);
		checkValue("lastInstruction", lastInstruction, word);
		writeAndCheck({20'h00100, 5'd1, opJal}, 5'd1);
		writeAndCheck(iType(12'h123, 5'd2, 3'b000, 5'd7, opAluImm), 5'd7);
		writeAndCheck(rType(7'h00, 5'd3, 5'd4, 3'b000, 5'd9), 5'd9);
		writeAndCheck(iType(12'h7ff, 5'd1, 3'b000, 5'd0, opAluImm), 5'd0);
	endtask

	task automatic loadTests();
		logic [2:0] widths [5];
		dataWord sentinel;
		dataWord memory;
		dataWord address;
		dataWord expected;
		int size;
		logic misaligned;
		widths = '{loadByte, loadHalf, loadWord, loadByteU, loadHalfU};
		foreach (widths[w]) begin
			for (int offset = 0; offset < 4; offset++) begin
				sentinel = $urandom | 32'h1;
				runStep(iType(12'h000, 5'd0, 3'b000, 5'd10, opAluImm), sentinel, '0);
				size = (widths[w][1:0] == 2'b00) ? 1 : (widths[w][1:0] == 2'b01) ? 2 : 4;
				misaligned = offset + size > 4;
				memory = $urandom;
				address = $urandom;
				address[1:0] = offset[1:0];
				// Crossing loads still retire but write zero
				expected = misaligned ? '0 : alignedLoad(widths[w], offset[1:0], memory);
				present(iType(12'h000, 5'd6, widths[w], 5'd10, opLoad), address, memory,
					1'b0, 1'b1);
				checkFlag("expectingLoad", expectingLoad, !misaligned);
				retire();
				checkRegister(5'd10, expected);
			end
		end
		sentinel = $urandom;
		runStep(iType(12'h000, 5'd0, 3'b000, 5'd10, opAluImm), sentinel, '0);
		// Store with imm[4:0] landing on the rd field of x10
		present({7'h00, 5'd8, 5'd6, 3'b010, 5'd10, opStore}, $urandom, $urandom, 1'b0, 1'b1);
		checkFlag("expectingLoad", expectingLoad, 1'b0);
		retire();
		checkRegister(5'd10, sentinel);
	endtask

	task automatic csrTests();
		dataWord first;
		dataWord second;
		first = $urandom;
		second = $urandom;
		runStep(iType(csrMscratch, 5'd1, 3'b001, 5'd0, opSystem), first, '0);
		checkCsr(csrMscratch, first);
		runStep(iType(csrMscratch, 5'd1, 3'b001, 5'd11, opSystem), second, '0);
		checkRegister(5'd11, first);
		checkCsr(csrMscratch, second);
		runStep(iType(csrMscratch, 5'd2, 3'b010, 5'd0, opSystem), $urandom, '0);
		checkCsr(csrMscratch, second);
		checkRegister(5'd0, '0);
		writeAndCheck(iType(12'h001, 5'd0, 3'b000, 5'd12, opAluImm), 5'd12);
		runStep(iType(12'h7c0, 5'd1, 3'b001, 5'd12, opSystem), $urandom, '0);
		checkRegister(5'd12, '0);
		checkCsr(12'h7c0, '0);
		first = $urandom | 32'h3;
		runStep(iType(csrMtvec, 5'd1, 3'b001, 5'd0, opSystem), first, '0);
		checkCsr(csrMtvec, first & ~32'h3);
	endtask

	task automatic stallTests();
		dataWord previous;
		previous = iType(12'h055, 5'd0, 3'b000, 5'd13, opAluImm);
		runStep(previous, $urandom, '0);
		present(rType(7'h00, 5'd1, 5'd2, 3'b000, 5'd14), $urandom, '0, 1'b1, 1'b1);
		checkFlag("invalidInstruction", invalidInstruction, 1'b0);
		retire();
		checkRegister(5'd14, '0);
		checkValue("lastInstruction", lastInstruction, previous);
		checkFlag("currentPipeStall", currentPipeStall, 1'b1);
		// Back-pressure with stepPipe low
		present(rType(7'h00, 5'd1, 5'd2, 3'b000, 5'd15), $urandom, '0, 1'b0, 1'b0);
		retire();
		checkRegister(5'd15, '0);
		checkValue("lastInstruction", lastInstruction, previous);
		checkFlag("currentPipeStall", currentPipeStall, 1'b1);
		runStep(previous, $urandom, '0);
		checkFlag("currentPipeStall", currentPipeStall, 1'b0);
	endtask

	task automatic flagTests();
		dataWord badAdd;
		badAdd = rType(7'h01, 5'd1, 5'd2, 3'b000, 5'd16);
		present(32'h0ff0000f, '0, '0, 1'b0, 1'b1);
		checkFlag("isFence", isFence, 1'b1);
		checkFlag("invalidInstruction", invalidInstruction, 1'b0);
		retire();
		present(32'h30200073, '0, '0, 1'b0, 1'b1);
		checkFlag("isRET", isRET, 1'b1);
		checkFlag("invalidInstruction", invalidInstruction, 1'b0);
		retire();
		present(32'h00000000, '0, '0, 1'b0, 1'b1);
		checkFlag("invalidInstruction", invalidInstruction, 1'b1);
		retire();
		present(badAdd, $urandom, '0, 1'b0, 1'b1);
		checkFlag("invalidInstruction", invalidInstruction, 1'b1);
		retire();
		checkFlag("active", active, 1'b1);
		checkValue("lastInstruction", lastInstruction, badAdd);
	endtask

	initial begin
		#(testCount * 200 * clockPeriod);
		$display("Timeout: the tests did not finish within %0d cycles", testCount * 200);
		abortRun();
	end

	initial begin
		void'($urandom(44023));
		arstN = 1'b0;
		stepPipe = 1'b0;
		pipeStall = 1'b0;
		currentInstruction = '0;
		aluResultData = '0;
		memoryDataRead = '0;
		debugRegisterAddress = '0;
		debugCsrAddress = '0;
		repeat (8) @(posedge clk);
		#1;
		arstN = 1'b1;
		checkFlag("active", active, 1'b0);
		checkFlag("currentPipeStall", currentPipeStall, 1'b0);
		checkValue("lastInstruction", lastInstruction, '0);
		resultWrites();
		loadTests();
		csrTests();
		stallTests();
		flagTests();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
rtl/rvWbPkg.sv
rtl/PipeStage.sv
rtl/InstructionDecode.sv
rtl/LoadAlign.sv
rtl/PipeStore.sv
rtl/RegisterFile.sv
rtl/CsrFile.sv
rtl/WritebackTop.sv
sim/WritebackTop_assert.sv
sim/WritebackTb.sv

//--- Makefile
TOP = WritebackTb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
